//--- uart_settings.svh
/*
 * UART build-time settings
 * Clock and bit rates, the derived bit period and the register map
 * shared by the transmit and receive peripherals
 */

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// System clock in Hz
`define UART_CLK_HZ        10_000_000
// Serial bit rate, gives 16 clocks per bit at the clock above
`define UART_BIT_RATE      625_000
// Clocks per serial bit, default for both cores
`define UART_CLKS_PER_BIT  (`UART_CLK_HZ / `UART_BIT_RATE)

// Data register, byte in bits 7:0
`define UART_REG_DATA      6'h0
// Status register, flags in the low bits
`define UART_REG_STATUS    6'h4

`endif

//--- uart_pkg.sv
/*
 * UART shared types
 * Vector widths used across the bus wrappers and cores,
 * plus the state encodings of the transmit and receive FSMs
 */

package uart_pkg;

    typedef logic [7:0]  byte_t;      // One serial data byte
    typedef logic [31:0] word_t;      // One bus data word
    typedef logic [5:0]  reg_addr_t;  // Offset inside one peripheral
    typedef logic [6:0]  bus_addr_t;  // Top-level address, bit 6 picks RX
    typedef logic [1:0]  access_t;    // Active-low access size, 3 means idle
    typedef logic [2:0]  bit_idx_t;   // Data bit position within a frame

    typedef enum logic [1:0] {
        TX_IDLE,   // Line high, waiting for a byte
        TX_START,  // Driving the start bit
        TX_DATA,   // Shifting out data bits
        TX_STOP    // Driving the stop bit
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,   // Waiting for a falling edge
        RX_START,  // Checking the start bit at mid-bit
        RX_DATA,   // Sampling data bits
        RX_STOP    // Checking the stop bit
    } rx_state_t;

endpackage

//--- uart_tx.sv
/*
 * UART transmitter core
 * Sends one byte per request as an 8N1 frame, LSB first
 * Every bit lasts CLKS_PER_BIT clocks; busy covers the whole frame
 */

`include "uart_settings.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tx_start,  // Frame request, only taken while idle
    input  uart_pkg::byte_t tx_data,   // Byte to send, captured with tx_start
    output logic            txd,       // Serial line, idles high
    output logic            tx_busy    // High from the edge after the request to end of stop
);
    import uart_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    tx_state_t        state;     // Frame position
    logic [CNT_W-1:0] baud_cnt;  // Clocks spent in the current bit
    bit_idx_t         bit_idx;   // Data bit currently on the line
    byte_t            shift_q;   // Remaining data bits, next one in bit 0
    logic             bit_done;  // Last clock of the current bit

    assign bit_done = (baud_cnt == CNT_LAST);  // Shared end-of-bit strobe
    assign tx_busy  = (state != TX_IDLE);      // Registered state, so busy rises at edge N+1

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;                  // Line idles in the mark state
        end else begin
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    if (tx_start) begin
                        state <= TX_START;
                        txd   <= 1'b0;         // Start bit goes out on the next edge
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state    <= TX_DATA;
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        txd      <= shift_q[0];  // LSB follows the start bit
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;     // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shift_q[0];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state    <= TX_IDLE;   // Busy drops after the last stop clock
                        baud_cnt <= '0;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data path holds no control state and needs no reset
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_q <= tx_data;                                 // Capture the byte with the request
        end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
            shift_q <= shift_q >> 1;                            // Bring the next bit down to bit 0
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        (state == TX_IDLE) |-> txd)
        else $error("txd low while transmitter idle");

endmodule

//--- uart_rx.sv
/*
 * UART receiver core
 * Synchronizes rxd, finds the start edge and samples each bit at its middle
 * One byte is held until consumed; RTS mirrors the held flag and a frame
 * that lands on a full holding register sets overrun instead
 */

`include "uart_settings.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rxd,           // Asynchronous serial input
    input  logic            rx_consume,    // Data register read that frees the holding register
    input  logic            rx_clear_ovr,  // Status register read that clears overrun
    output logic            rx_valid,      // Holding register full
    output uart_pkg::byte_t rx_data,       // Held byte
    output logic            rx_overrun,    // A frame was dropped on a full register
    output logic            rts            // Asks the far end to pause while full
);
    import uart_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic             rxd_meta;    // First synchronizer stage
    logic             rxd_sync;    // Second stage that the rest of the logic uses
    logic             rxd_last;    // Previous synchronized value for edge detect
    logic             start_edge;  // Falling edge on the synchronized line
    rx_state_t        state;
    logic [CNT_W-1:0] baud_cnt;    // Clocks since the last sample point
    bit_idx_t         bit_idx;     // Data bit being sampled
    byte_t            shift_q;     // Data bits gathered so far with the LSB arriving first
    logic             bit_done;
    logic             frame_done;  // Stop bit sampled high
    logic             load;        // Frame goes into the holding register
    logic             valid_next;

    assign start_edge = rxd_last & ~rxd_sync;
    assign bit_done   = (baud_cnt == CNT_LAST);
    assign frame_done = (state == RX_STOP) && bit_done && rxd_sync;  // Framing errors drop out here
    assign load       = frame_done && (!rx_valid || rx_consume);     // A same-cycle read frees room
    assign valid_next = frame_done || (rx_valid && !rx_consume);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;          // Preset to the idle level so reset makes no false edge
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (start_edge) state <= RX_START;
                end
                RX_START: begin
                    if (baud_cnt == CNT_HALF) begin
                        baud_cnt <= '0;    // Later samples fall a whole bit apart
                        bit_idx  <= '0;
                        state    <= rxd_sync ? RX_IDLE : RX_DATA;  // High here was a glitch
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;  // Back at mid stop bit and ready for the next edge
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid   <= 1'b0;
            rts        <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_valid <= valid_next;
            rts      <= valid_next;                      // Pauses the sender while a byte is held
            if (frame_done && !load) rx_overrun <= 1'b1; // Setting wins over a same-cycle clear
            else if (rx_clear_ovr)   rx_overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) shift_q <= {rxd_sync, shift_q[7:1]};
        if (load) rx_data <= shift_q;
    end

    a_valid_until_read: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rx_valid) |-> $past(rx_consume))
        else $error("rx_valid cleared without a data read");

endmodule

//--- uart_periph_tx.sv
/*
 * UART transmit peripheral
 * A write of any size sends data_in[7:0]; the status register
 * reports busy in bit 0 and the interrupt means ready for a byte
 */

`include "uart_settings.svh"

module uart_periph_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::reg_addr_t address,       // Offset within this peripheral
    input  uart_pkg::word_t     data_in,       // Write data with the byte in the low 8 bits
    input  uart_pkg::access_t   data_write_n,  // Write strobe where 3 means no write
    output uart_pkg::word_t     data_out,      // Combinational read data
    output logic                txd,           // Serial output line
    output logic                tx_irq         // High while a byte can be accepted
);

    logic tx_start;  // Write strobe into the core
    logic tx_busy;   // Frame in progress

    assign tx_start = (data_write_n != 2'b11);  // Writes while busy are dropped inside the core

    uart_tx #(
        .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
    ) uart_tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_data (data_in[7:0]),
        .txd     (txd),
        .tx_busy (tx_busy)
    );

    assign tx_irq   = ~tx_busy;                  // Software may write when this is set
    assign data_out = (address == `UART_REG_STATUS) ? {31'd0, tx_busy} : 32'd0;

endmodule

//--- uart_periph_rx.sv
/*
 * UART receive peripheral
 * Data register returns the held byte and frees it; status returns
 * valid in bit 0 and overrun in bit 1 and clears overrun on read
 */

`include "uart_settings.svh"

module uart_periph_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::reg_addr_t address,      // Offset within this peripheral
    input  uart_pkg::access_t   data_read_n,  // 3 = no read, otherwise a read
    input  logic                rxd,          // Serial input line
    output uart_pkg::word_t     data_out,     // Combinational read data
    output logic                rts,          // Flow control towards the sender
    output logic                rx_irq        // High while a byte is held
);
    import uart_pkg::*;

    logic  rd_access;   // Read strobe active this cycle
    logic  rx_consume;  // Data register read
    logic  rx_clear;    // Status register read
    logic  rx_valid;
    logic  rx_overrun;
    byte_t rx_data;

    assign rd_access  = (data_read_n != 2'b11);
    assign rx_consume = rd_access && (address == `UART_REG_DATA);    // Valid drops at the next edge
    assign rx_clear   = rd_access && (address == `UART_REG_STATUS);  // Status read is read-to-clear

    uart_rx #(
        .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
    ) uart_rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (rxd),
        .rx_consume  (rx_consume),
        .rx_clear_ovr(rx_clear),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_overrun  (rx_overrun),
        .rts         (rts)
    );

    assign rx_irq = rx_valid;  // Interrupt while there is something to read

    // Flags show their value before the read takes effect
    assign data_out = (address == `UART_REG_DATA)   ? {24'd0, rx_data} :
                      (address == `UART_REG_STATUS) ? {30'd0, rx_overrun, rx_valid} :
                      32'd0;

endmodule

//--- uart_periph_bus.sv
/*
 * UART peripheral pair on the TinyQV peripheral bus
 * Address bit 6 picks RX (1) or TX (0); only the picked side sees its strobe
 * uo_out[0] carries TX data, uo_out[1] carries RTS and ui_in[7] feeds RX
 * user_interrupt[0] is TX ready and user_interrupt[1] is RX byte held
 */

module uart_periph_bus (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::byte_t     ui_in,           // Input PMOD with RX on bit 7
    output uart_pkg::byte_t     uo_out,          // Output PMOD
    input  uart_pkg::bus_addr_t address,         // Bit 6 selects the peripheral
    input  uart_pkg::word_t     data_in,         // Write data from the core
    input  uart_pkg::access_t   data_write_n,    // 3 = no write
    input  uart_pkg::access_t   data_read_n,     // 3 = no read
    output uart_pkg::word_t     data_out,        // Read data valid with the read strobe
    output logic                data_ready,      // Every access completes at once
    output logic [1:0]          user_interrupt   // {rx held, tx ready}
);
    import uart_pkg::*;

    logic      sel_rx;        // Access targets the receiver
    reg_addr_t reg_addr;      // Offset passed to both peripherals
    access_t   tx_write_n;    // Write strobe seen by TX
    access_t   rx_read_n;     // Read strobe seen by RX
    word_t     tx_data_out;
    word_t     rx_data_out;
    logic      txd;
    logic      rts;
    logic      tx_irq;
    logic      rx_irq;

    assign sel_rx   = address[6];
    assign reg_addr = address[5:0];

    // TX has no read side effects and RX has no writable registers,
    // so each side only needs the one strobe that can change it
    assign tx_write_n = sel_rx ? 2'b11 : data_write_n;
    assign rx_read_n  = sel_rx ? data_read_n : 2'b11;

    uart_periph_tx uart_periph_tx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (reg_addr),
        .data_in     (data_in),
        .data_write_n(tx_write_n),
        .data_out    (tx_data_out),
        .txd         (txd),
        .tx_irq      (tx_irq)
    );

    uart_periph_rx uart_periph_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (reg_addr),
        .data_read_n(rx_read_n),
        .rxd        (ui_in[7]),
        .data_out   (rx_data_out),
        .rts        (rts),
        .rx_irq     (rx_irq)
    );

    assign data_out       = sel_rx ? rx_data_out : tx_data_out;  // Same-cycle read mux
    assign data_ready     = 1'b1;                                // No wait states
    assign uo_out         = {6'd0, rts, txd};                    // Unused PMOD pins stay low
    assign user_interrupt = {rx_irq, tx_irq};

endmodule

//--- tb_uart_periph.sv
/*
 * Directed testbench for the UART peripheral pair
 * Drives the peripheral bus and the RX pin and watches the TX pin
 * Covers reset state, transmit, back-pressure, receive, overrun and loopback
 */

`include "uart_settings.svh"

module tb_uart_periph;
    timeunit 1ns;
    timeprecision 1ns;

    import uart_pkg::*;

    localparam int        CLK_PERIOD  = 100;                     // ns
    localparam int        BIT_CLKS    = `UART_CLKS_PER_BIT;      // Clocks per serial bit
    localparam int        CYCLE_LIMIT = 12000;                   // About 40 frames plus margin
    localparam bus_addr_t TX_DATA     = {1'b0, `UART_REG_DATA};
    localparam bus_addr_t TX_STATUS   = {1'b0, `UART_REG_STATUS};
    localparam bus_addr_t RX_DATA     = {1'b1, `UART_REG_DATA};
    localparam bus_addr_t RX_STATUS   = {1'b1, `UART_REG_STATUS};

    logic        clk;
    logic        rst_n;
    byte_t       ui_in;
    byte_t       uo_out;
    bus_addr_t   address;
    word_t       data_in;
    access_t     data_write_n;
    access_t     data_read_n;
    word_t       data_out;
    logic        data_ready;
    logic [1:0]  user_interrupt;
    logic        rx_line;          // Serial line driven by the testbench
    logic        loopback;         // Ties the TX pin back to the RX pin
    int unsigned cycle_count = 0;

    assign ui_in = {(loopback ? uo_out[0] : rx_line), 7'd0};  // Only bit 7 is used by the DUT

    uart_periph_bus uart_periph_bus_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ui_in         (ui_in),
        .uo_out        (uo_out),
        .address       (address),
        .data_in       (data_in),
        .data_write_n  (data_write_n),
        .data_read_n   (data_read_n),
        .data_out      (data_out),
        .data_ready    (data_ready),
        .user_interrupt(user_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // One-cycle write, strobe released at the following falling edge
    task automatic bus_write(input bus_addr_t addr, input word_t value);
        @(negedge clk);
        address      = addr;
        data_in      = value;
        data_write_n = 2'b10;             // 32-bit write
        @(negedge clk);
        data_write_n = 2'b11;
    endtask

    task automatic bus_read(input bus_addr_t addr, output word_t value);
        @(negedge clk);
        address     = addr;
        data_read_n = 2'b10;              // 32-bit read
        #(CLK_PERIOD / 4);                // Read data is combinational, settled well before the edge
        value = data_out;
        check_bit(data_ready, 1'b1, "data_ready");
        @(negedge clk);
        data_read_n = 2'b11;
    endtask

    task automatic send_serial_byte(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};      // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_line = frame[i];
            repeat (BIT_CLKS - 1) @(negedge clk);
        end
    endtask

    // Called right after a falling edge; samples every bit at its middle
    task automatic capture_serial_byte(output byte_t value);
        int waited;
        waited = 0;
        while (uo_out[0] && waited < 4 * BIT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (uo_out[0]) begin
            $display("No start bit appeared on the TX pin within %0d cycles", 4 * BIT_CLKS);
            abort_run();
        end
        repeat (BIT_CLKS / 2 - 1) @(negedge clk);   // Half a cycle in already, move to mid-bit
        check_bit(uo_out[0], 1'b0, "TX start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            value[i] = uo_out[0];                    // LSB arrives first
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_bit(uo_out[0], 1'b1, "TX stop bit");
    endtask

    task automatic wait_tx_idle(input int max_polls);
        word_t status;
        int    polls;
        polls  = 0;
        status = 32'd1;
        while (status[0] && polls < max_polls) begin
            bus_read(TX_STATUS, status);
            polls++;
        end
        if (status[0]) begin
            $display("Transmitter still busy after %0d status polls", max_polls);
            abort_run();
        end
    endtask

    task automatic wait_rx_held(input int max_cycles);
        int waited;
        waited = 0;
        while (!user_interrupt[1] && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!user_interrupt[1]) begin
            $display("Receiver did not report a held byte within %0d cycles", max_cycles);
            abort_run();
        end
    endtask

    task automatic reset_state();
        word_t rd;
        bus_read(TX_STATUS, rd);
        check_word(rd, 32'd0, "TX status after reset");
        bus_read(RX_STATUS, rd);
        check_word(rd, 32'd0, "RX status after reset");
        check_bit(user_interrupt[0], 1'b1, "TX ready interrupt after reset");
        check_bit(user_interrupt[1], 1'b0, "RX held interrupt after reset");
        check_byte(uo_out, 8'h01, "uo_out after reset");  // TX idle high, RTS and spare pins low
    endtask

    task automatic transmit_frame();
        byte_t got;
        bus_write(TX_DATA, 32'hffff_ff4b);                  // Upper bits must be ignored
        check_bit(uo_out[0], 1'b0, "TX line one edge after the write");
        capture_serial_byte(got);
        check_byte(got, 8'h4b, "transmitted byte");
        wait_tx_idle(20);
    endtask

    task automatic tx_backpressure();
        byte_t got;
        word_t rd;
        bus_write(TX_DATA, 32'h0000_00c5);
        fork
            capture_serial_byte(got);
            begin
                repeat (2) @(negedge clk);
                bus_read(TX_STATUS, rd);
                check_word(rd, 32'd1, "TX status during a frame");
                check_bit(user_interrupt[0], 1'b0, "TX ready interrupt during a frame");
                bus_write(TX_DATA, 32'h0000_003c);          // Dropped while busy
            end
        join
        check_byte(got, 8'hc5, "byte sent under back-pressure");
        wait_tx_idle(20);
        check_bit(user_interrupt[0], 1'b1, "TX ready interrupt after the frame");
        for (int i = 0; i < 2 * BIT_CLKS; i++) begin
            @(negedge clk);
            check_bit(uo_out[0], 1'b1, "TX line after a dropped write");
        end
    endtask

    task automatic receive_frame();
        word_t rd;
        send_serial_byte(8'h96);
        wait_rx_held(4 * BIT_CLKS);
        check_bit(uo_out[1], 1'b1, "RTS while a byte is held");
        bus_read(RX_DATA, rd);
        check_word(rd, 32'h0000_0096, "RX data");
        bus_read(RX_STATUS, rd);
        check_word(rd, 32'd0, "RX status after the data read");
        check_bit(uo_out[1], 1'b0, "RTS after the data read");
        check_bit(user_interrupt[1], 1'b0, "RX held interrupt after the data read");
    endtask

    task automatic rx_overrun_flag();
        word_t rd;
        send_serial_byte(8'h71);
        send_serial_byte(8'he8);                            // Lands on a full holding register
        wait_rx_held(4 * BIT_CLKS);
        bus_read(RX_DATA, rd);
        check_word(rd, 32'h0000_0071, "RX data after overrun");
        bus_read(RX_STATUS, rd);
        check_word(rd, 32'd2, "RX status with overrun");
        bus_read(RX_STATUS, rd);
        check_word(rd, 32'd0, "RX status after overrun read");
        check_bit(uo_out[1], 1'b0, "RTS after overrun handling");
    endtask

    task automatic serial_loopback();
        byte_t sent[$];
        byte_t b;
        word_t rd;
        loopback = 1'b1;
        for (int i = 0; i < 16; i++) begin
            b = byte_t'($urandom());
            sent.push_back(b);
            wait_tx_idle(100);
            bus_write(TX_DATA, {24'd0, b});
            wait_rx_held(12 * BIT_CLKS);
            bus_read(RX_DATA, rd);
            check_word(rd, {24'd0, sent.pop_front()}, "loopback byte");
        end
        loopback = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;             // No access
        data_read_n  = 2'b11;
        rx_line      = 1'b1;              // Serial idle level
        loopback     = 1'b0;
        void'($urandom(32'h31cdc1b5));
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        transmit_frame();
        tx_backpressure();
        receive_frame();
        rx_overrun_flag();
        serial_loopback();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_periph_tx.sv
uart_periph_rx.sv
uart_periph_bus.sv
tb_uart_periph.sv

//--- run_sim.sh
#!/bin/sh
# Builds the UART peripheral testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_uart_periph -f flist.f -o sim_uart
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_uart > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
